// File: design/pe_pkg.sv
`default_nettype none

package pe_pkg;

  // Array geometry and arithmetic widths
  localparam int COLS      = 4;
  localparam int ROWS      = 2;
  localparam int X_BITS    = 8;
  localparam int K_BITS    = 8;
  localparam int M_BITS    = X_BITS + K_BITS;
  localparam int Y_BITS    = 20;
  localparam int DELAY_MUL = 2;
  localparam int KW_MAX    = 4;
  localparam int CIN_BITS  = 8;
  localparam int KW2_BITS  = 2;

  // Tag is padded out to one byte
  localparam int TAG_PAD_BITS = 8 - KW2_BITS - 2;

  // Register block
  localparam int AXIL_ADDR_BITS = 4;
  localparam int AXIL_DATA_BITS = 32;
  localparam int GRP_CNT_BITS   = 16;
  localparam logic [AXIL_ADDR_BITS-1:0] ADDR_CIN_LEN = 4'h0;
  localparam logic [AXIL_ADDR_BITS-1:0] ADDR_KW2     = 4'h4;
  localparam logic [AXIL_ADDR_BITS-1:0] ADDR_GRP_CNT = 4'h8;

  typedef struct packed {
    logic [KW2_BITS-1:0]     kw2;
    logic                    is_cin_last;
    logic                    is_w_first_clk;
    logic [TAG_PAD_BITS-1:0] is_ctr_pad;
  } beat_tag_st;

  typedef struct packed {
    logic       valid;
    logic       last;
    beat_tag_st tag;
  } pe_ctrl_st;

  typedef struct packed {
    logic [CIN_BITS-1:0] cin_len;
    logic [KW2_BITS-1:0] kw2;
  } engine_cfg_st;

  typedef logic [ROWS-1:0][X_BITS-1:0]             pixels_t;
  typedef logic [COLS-1:0][K_BITS-1:0]             weights_t;
  typedef logic [COLS-1:0][ROWS-1:0][Y_BITS-1:0]   out_data_t;

endpackage

`default_nettype wire

// File: design/delay_line.sv
`default_nettype none

module delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk,
  input  logic     resetn,
  input  logic     en,
  input  payload_t d,
  output payload_t q
);

  payload_t stage [DEPTH];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      stage <= '{default: '0};
    end else if (en) begin
      stage[0] <= d;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign q = stage[DEPTH-1];

endmodule

`default_nettype wire

// File: design/beat_tagger.sv
`default_nettype none

module beat_tagger (
  input  logic                 clk,
  input  logic                 resetn,
  input  pe_pkg::engine_cfg_st cfg,
  input  logic                 cfg_written,
  input  logic                 s_valid,
  input  logic                 s_ready,
  output pe_pkg::beat_tag_st   tag
);

  logic [pe_pkg::CIN_BITS-1:0] cin_cnt;
  logic                        first_beat;
  logic                        cin_last;
  logic                        xfer;

  assign xfer     = s_valid && s_ready;
  assign cin_last = (cin_cnt == cfg.cin_len - 1'b1);

  // Position in the channel loop
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cin_cnt    <= '0;
      first_beat <= 1'b1;
    end else if (cfg_written) begin
      cin_cnt    <= '0;
      first_beat <= 1'b1;
    end else if (xfer) begin
      first_beat <= 1'b0;
      if (cin_last) begin
        cin_cnt <= '0;
      end else begin
        cin_cnt <= cin_cnt + 1'b1;
      end
    end
  end

  assign tag = '{
    kw2:            cfg.kw2,
    is_cin_last:    cin_last,
    is_w_first_clk: first_beat,
    is_ctr_pad:     '0
  };

  // Zero channel count would never close a group
  a_cin_len_nonzero: assert property (
    @(posedge clk) disable iff (!resetn)
    s_valid |-> cfg.cin_len != '0
  );

endmodule

`default_nettype wire

// File: design/engine_regs.sv
`default_nettype none

module engine_regs (
  input  logic                                clk,
  input  logic                                resetn,
  input  logic [pe_pkg::AXIL_ADDR_BITS-1:0]   s_axil_awaddr,
  input  logic                                s_axil_awvalid,
  output logic                                s_axil_awready,
  input  logic [pe_pkg::AXIL_DATA_BITS-1:0]   s_axil_wdata,
  input  logic [pe_pkg::AXIL_DATA_BITS/8-1:0] s_axil_wstrb,
  input  logic                                s_axil_wvalid,
  output logic                                s_axil_wready,
  output logic                                s_axil_bvalid,
  output logic [1:0]                          s_axil_bresp,
  input  logic                                s_axil_bready,
  input  logic [pe_pkg::AXIL_ADDR_BITS-1:0]   s_axil_araddr,
  input  logic                                s_axil_arvalid,
  output logic                                s_axil_arready,
  output logic                                s_axil_rvalid,
  output logic [pe_pkg::AXIL_DATA_BITS-1:0]   s_axil_rdata,
  output logic [1:0]                          s_axil_rresp,
  input  logic                                s_axil_rready,
  input  logic                                m_valid,
  input  logic                                m_ready,
  output pe_pkg::engine_cfg_st                cfg,
  output logic                                cfg_written
);

  logic                              wr_go;
  logic                              rd_go;
  logic [pe_pkg::GRP_CNT_BITS-1:0]   grp_cnt;
  logic [pe_pkg::AXIL_DATA_BITS-1:0] rd_word;

  assign wr_go          = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
  assign rd_go          = s_axil_arvalid && !s_axil_rvalid;
  assign s_axil_awready = wr_go;
  assign s_axil_wready  = wr_go;
  assign s_axil_arready = rd_go;
  assign s_axil_bresp   = 2'b00;
  assign s_axil_rresp   = 2'b00;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      s_axil_bvalid <= 1'b0;
      cfg_written   <= 1'b0;
      cfg.cin_len   <= pe_pkg::CIN_BITS'(1);
      cfg.kw2       <= '0;
    end else begin
      cfg_written <= 1'b0;
      if (wr_go) begin
        s_axil_bvalid <= 1'b1;
        case (s_axil_awaddr)
          pe_pkg::ADDR_CIN_LEN: begin
            cfg_written <= 1'b1;
            if (s_axil_wstrb[0]) cfg.cin_len <= s_axil_wdata[pe_pkg::CIN_BITS-1:0];
          end
          pe_pkg::ADDR_KW2: begin
            cfg_written <= 1'b1;
            // Clamp to the widest kernel the array supports
            if (s_axil_wstrb[0]) begin
              if (s_axil_wdata > pe_pkg::KW_MAX / 2) begin
                cfg.kw2 <= pe_pkg::KW2_BITS'(pe_pkg::KW_MAX / 2);
              end else begin
                cfg.kw2 <= s_axil_wdata[pe_pkg::KW2_BITS-1:0];
              end
            end
          end
          default: ;
        endcase
      end else if (s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
    end
  end

  always_comb begin
    rd_word = '0;
    case (s_axil_araddr)
      pe_pkg::ADDR_CIN_LEN: rd_word[pe_pkg::CIN_BITS-1:0]     = cfg.cin_len;
      pe_pkg::ADDR_KW2:     rd_word[pe_pkg::KW2_BITS-1:0]     = cfg.kw2;
      pe_pkg::ADDR_GRP_CNT: rd_word[pe_pkg::GRP_CNT_BITS-1:0] = grp_cnt;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      s_axil_rvalid <= 1'b0;
    end else if (rd_go) begin
      s_axil_rvalid <= 1'b1;
    end else if (s_axil_rready) begin
      s_axil_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_go) s_axil_rdata <= rd_word;
  end

  // Completed output groups, wraps
  always_ff @(posedge clk) begin
    if (!resetn) begin
      grp_cnt <= '0;
    end else if (m_valid && m_ready) begin
      grp_cnt <= grp_cnt + 1'b1;
    end
  end

  a_bvalid_hold: assert property (
    @(posedge clk) disable iff (!resetn)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid
  );

endmodule

`default_nettype wire

// File: design/proc_engine.sv
`default_nettype none

module proc_engine (
  input  logic               clk,
  input  logic               resetn,
  input  logic               s_valid,
  input  logic               s_last,
  input  pe_pkg::pixels_t    s_pixels,
  input  pe_pkg::weights_t   s_weights,
  input  pe_pkg::beat_tag_st s_tag,
  output logic               s_ready,
  input  logic               m_ready,
  output logic               m_valid,
  output logic               m_last,
  output pe_pkg::out_data_t  m_data
);

  typedef logic signed [pe_pkg::M_BITS-1:0] product_t;

  logic                    en;
  logic                    run;
  logic                    sel_shift;
  logic                    sel_shift_next;
  logic                    shift_last;
  logic                    bypass_sum;
  logic                    bypass;
  logic                    acc_valid_next;
  logic                    last_next;
  pe_pkg::pe_ctrl_st       s_ctrl;
  pe_pkg::pe_ctrl_st       mul_ctrl;
  logic [pe_pkg::COLS-1:0] sum_start;
  logic [pe_pkg::COLS-1:0] clken_acc;
  logic [pe_pkg::COLS-1:0] start_lut [pe_pkg::KW_MAX/2+1];
  pe_pkg::out_data_t       acc;

  // Whole pipeline freezes under output back-pressure
  assign en      = m_ready || !m_valid;
  assign s_ready = en && !sel_shift && run;

  // Input held off for a cycle out of reset
  always_ff @(posedge clk) begin
    if (!resetn) run <= 1'b0;
    else         run <= 1'b1;
  end

  assign s_ctrl = '{valid: s_valid, last: s_last, tag: s_tag};

  delay_line #(
    .payload_t (pe_pkg::pe_ctrl_st),
    .DEPTH     (pe_pkg::DELAY_MUL)
  ) i_ctrl_dly (
    .clk    (clk),
    .resetn (resetn),
    .en     (s_ready),
    .d      (s_ctrl),
    .q      (mul_ctrl)
  );

  assign sel_shift_next = mul_ctrl.valid && mul_ctrl.tag.is_cin_last &&
                          (mul_ctrl.tag.kw2 != '0) && !sel_shift;

  always_ff @(posedge clk) begin
    if (!resetn)  sel_shift <= 1'b0;
    else if (en)  sel_shift <= sel_shift_next;
  end

  // Last flag of the closing beat, held across the merge step
  always_ff @(posedge clk) begin
    if (!resetn) begin
      shift_last <= 1'b0;
    end else if (en && sel_shift_next) begin
      shift_last <= mul_ctrl.last;
    end
  end

  // Columns that start a kernel window keep their own sum
  for (genvar k = 0; k <= pe_pkg::KW_MAX / 2; k++) begin : g_lut
    for (genvar c = 0; c < pe_pkg::COLS; c++) begin : g_col
      assign start_lut[k][c] = (c % (2 * k + 1)) == 0;
    end
  end

  assign sum_start = start_lut[mul_ctrl.tag.kw2];

  for (genvar c = 0; c < pe_pkg::COLS; c++) begin : g_clken
    assign clken_acc[c] = en && (sel_shift ? !sum_start[c] : mul_ctrl.valid);
  end

  // Set once a group closes, so the next product restarts the sum
  always_ff @(posedge clk) begin
    if (!resetn) begin
      bypass_sum <= 1'b0;
    end else if (en && mul_ctrl.valid && !sel_shift) begin
      bypass_sum <= mul_ctrl.tag.is_cin_last;
    end
  end

  assign bypass = !sel_shift && (bypass_sum || mul_ctrl.tag.is_w_first_clk);

  for (genvar r = 0; r < pe_pkg::ROWS; r++) begin : g_row
    for (genvar c = 0; c < pe_pkg::COLS; c++) begin : g_col
      logic signed [pe_pkg::X_BITS-1:0] pixel_q;
      logic signed [pe_pkg::K_BITS-1:0] weight_q;
      product_t                         prod;
      product_t                         prod_q;
      logic signed [pe_pkg::Y_BITS-1:0] prod_ext;
      logic signed [pe_pkg::Y_BITS-1:0] shift_in;
      logic signed [pe_pkg::Y_BITS-1:0] add_a;
      logic signed [pe_pkg::Y_BITS-1:0] add_b;
      logic signed [pe_pkg::Y_BITS-1:0] acc_q;

      always_ff @(posedge clk) begin
        if (s_ready) begin
          pixel_q  <= s_pixels[r];
          weight_q <= s_weights[c];
        end
      end

      assign prod = pixel_q * weight_q;

      delay_line #(
        .payload_t (product_t),
        .DEPTH     (pe_pkg::DELAY_MUL - 1)
      ) i_prod_dly (
        .clk    (clk),
        .resetn (resetn),
        .en     (s_ready),
        .d      (prod),
        .q      (prod_q)
      );

      if (c == 0) begin : g_edge
        assign shift_in = '0;
      end else begin : g_nbr
        assign shift_in = acc[c-1][r];
      end

      assign prod_ext = prod_q;
      assign add_a    = sel_shift ? shift_in : prod_ext;
      assign add_b    = bypass ? '0 : acc_q;

      always_ff @(posedge clk) begin
        if (!resetn)           acc_q <= '0;
        else if (clken_acc[c]) acc_q <= add_a + add_b;
      end

      assign acc[c][r] = acc_q;
    end
  end

  // Group is ready after its last product, or after the merge step
  assign acc_valid_next = sel_shift ||
                          (mul_ctrl.valid && mul_ctrl.tag.is_cin_last &&
                           mul_ctrl.tag.kw2 == '0);
  assign last_next      = sel_shift ? shift_last : mul_ctrl.last;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
    end else if (en) begin
      m_valid <= acc_valid_next;
      m_last  <= acc_valid_next && last_next;
    end
  end

  assign m_data = acc;

  a_out_stable: assert property (
    @(posedge clk) disable iff (!resetn)
    m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last)
  );

  // Merge step blocks input, then the merged group is presented
  a_shift_stall: assert property (
    @(posedge clk) disable iff (!resetn)
    en && sel_shift |-> !s_ready ##1 m_valid
  );

endmodule

`default_nettype wire

// File: design/engine_top.sv
`default_nettype none

module engine_top (
  input  logic                                clk,
  input  logic                                resetn,
  input  logic                                s_valid,
  output logic                                s_ready,
  input  logic                                s_last,
  input  pe_pkg::pixels_t                     s_pixels,
  input  pe_pkg::weights_t                    s_weights,
  output logic                                m_valid,
  input  logic                                m_ready,
  output logic                                m_last,
  output pe_pkg::out_data_t                   m_data,
  input  logic [pe_pkg::AXIL_ADDR_BITS-1:0]   s_axil_awaddr,
  input  logic                                s_axil_awvalid,
  output logic                                s_axil_awready,
  input  logic [pe_pkg::AXIL_DATA_BITS-1:0]   s_axil_wdata,
  input  logic [pe_pkg::AXIL_DATA_BITS/8-1:0] s_axil_wstrb,
  input  logic                                s_axil_wvalid,
  output logic                                s_axil_wready,
  output logic                                s_axil_bvalid,
  output logic [1:0]                          s_axil_bresp,
  input  logic                                s_axil_bready,
  input  logic [pe_pkg::AXIL_ADDR_BITS-1:0]   s_axil_araddr,
  input  logic                                s_axil_arvalid,
  output logic                                s_axil_arready,
  output logic                                s_axil_rvalid,
  output logic [pe_pkg::AXIL_DATA_BITS-1:0]   s_axil_rdata,
  output logic [1:0]                          s_axil_rresp,
  input  logic                                s_axil_rready
);

  pe_pkg::engine_cfg_st cfg;
  logic                 cfg_written;
  pe_pkg::beat_tag_st   tag;

  engine_regs i_engine_regs (
    .clk            (clk),
    .resetn         (resetn),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rready  (s_axil_rready),
    .m_valid        (m_valid),
    .m_ready        (m_ready),
    .cfg            (cfg),
    .cfg_written    (cfg_written)
  );

  beat_tagger i_beat_tagger (
    .clk         (clk),
    .resetn      (resetn),
    .cfg         (cfg),
    .cfg_written (cfg_written),
    .s_valid     (s_valid),
    .s_ready     (s_ready),
    .tag         (tag)
  );

  proc_engine i_proc_engine (
    .clk       (clk),
    .resetn    (resetn),
    .s_valid   (s_valid),
    .s_last    (s_last),
    .s_pixels  (s_pixels),
    .s_weights (s_weights),
    .s_tag     (tag),
    .s_ready   (s_ready),
    .m_ready   (m_ready),
    .m_valid   (m_valid),
    .m_last    (m_last),
    .m_data    (m_data)
  );

endmodule

`default_nettype wire

// File: sim/engine_tb.sv
`default_nettype none

module engine_tb;

  typedef logic [63:0] name_t;

  typedef struct packed {
    name_t      name;
    logic [7:0] cin_len;
    logic [1:0] kw2;
    logic [7:0] groups;
    logic       stall;
  } test_st;

  // Name, channels per group, kernel half-width, groups, random m_ready
  test_st tests [6] = '{
    '{"cin1_kw0", 8'd1,  2'd0, 8'd6, 1'b0},
    '{"cin3_kw0", 8'd3,  2'd0, 8'd5, 1'b0},
    '{"cin17kw0", 8'd17, 2'd0, 8'd3, 1'b0},
    '{"stall_k0", 8'd3,  2'd0, 8'd6, 1'b1},
    '{"cin3_kw1", 8'd3,  2'd1, 8'd4, 1'b1},
    '{"cin2_kw2", 8'd2,  2'd2, 8'd4, 1'b0}
  };

  logic                                clk = 1'b0;
  logic                                resetn;
  logic                                s_valid;
  logic                                s_ready;
  logic                                s_last;
  pe_pkg::pixels_t                     s_pixels;
  pe_pkg::weights_t                    s_weights;
  logic                                m_valid;
  logic                                m_ready;
  logic                                m_last;
  pe_pkg::out_data_t                   m_data;
  logic [pe_pkg::AXIL_ADDR_BITS-1:0]   s_axil_awaddr;
  logic                                s_axil_awvalid;
  logic                                s_axil_awready;
  logic [pe_pkg::AXIL_DATA_BITS-1:0]   s_axil_wdata;
  logic [pe_pkg::AXIL_DATA_BITS/8-1:0] s_axil_wstrb;
  logic                                s_axil_wvalid;
  logic                                s_axil_wready;
  logic                                s_axil_bvalid;
  logic [1:0]                          s_axil_bresp;
  logic                                s_axil_bready;
  logic [pe_pkg::AXIL_ADDR_BITS-1:0]   s_axil_araddr;
  logic                                s_axil_arvalid;
  logic                                s_axil_arready;
  logic                                s_axil_rvalid;
  logic [pe_pkg::AXIL_DATA_BITS-1:0]   s_axil_rdata;
  logic [1:0]                          s_axil_rresp;
  logic                                s_axil_rready;

  int seed = 32'h519b_44b1;
  int data_errs = 0;
  int flag_errs = 0;
  int word_errs = 0;
  int cycles = 0;
  int cycle_limit;
  int groups_total = 0;

  // Beats waiting to be sent and groups waiting to be seen
  pe_pkg::pixels_t   px_q [$];
  pe_pkg::weights_t  wt_q [$];
  logic              last_q [$];
  pe_pkg::out_data_t exp_q [$];
  logic              exp_last_q [$];

  engine_top i_engine_top (
    .clk            (clk),
    .resetn         (resetn),
    .s_valid        (s_valid),
    .s_ready        (s_ready),
    .s_last         (s_last),
    .s_pixels       (s_pixels),
    .s_weights      (s_weights),
    .m_valid        (m_valid),
    .m_ready        (m_ready),
    .m_last         (m_last),
    .m_data         (m_data),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rready  (s_axil_rready)
  );

  always #4 clk = ~clk;

  task automatic print_counts();
    $display("Error counts: data %0d, last %0d, register %0d", data_errs, flag_errs, word_errs);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped taking beats or giving groups", cycles);
      print_counts();
      $display("test failed");
      $finish;
    end
  end

  function automatic int total_beats();
    int n;
    n = 0;
    for (int i = 0; i < $size(tests); i++) begin
      n += tests[i].cin_len * tests[i].groups;
    end
    return n;
  endfunction

  task automatic check_data(input name_t name, input pe_pkg::out_data_t exp,
                            input pe_pkg::out_data_t act);
    if (act !== exp) begin
      data_errs++;
      $display("[ERROR] %s: m_data expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input name_t name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("[ERROR] %s: m_last expected %b, got %b", name, exp, act);
    end
  endtask

  task automatic check_word(input name_t name, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      word_errs++;
      $display("[ERROR] %s: %s expected %h, got %h", name, what, exp, act);
    end
  endtask

  task automatic check_resp(input name_t name, input string what,
                            input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      word_errs++;
      $display("[ERROR] %s: %s expected %b, got %b", name, what, exp, act);
    end
  endtask

  task automatic write_reg(input logic [pe_pkg::AXIL_ADDR_BITS-1:0] addr,
                           input logic [31:0] data, output logic [1:0] resp);
    @(negedge clk);
    s_axil_awaddr  = addr;
    s_axil_awvalid = 1'b1;
    s_axil_wdata   = data;
    s_axil_wvalid  = 1'b1;
    s_axil_bready  = 1'b1;
    @(posedge clk);
    while (!(s_axil_awready && s_axil_wready)) @(posedge clk);
    @(negedge clk);
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    @(posedge clk);
    while (!s_axil_bvalid) @(posedge clk);
    resp = s_axil_bresp;
    @(negedge clk);
    s_axil_bready = 1'b0;
  endtask

  task automatic read_reg(input logic [pe_pkg::AXIL_ADDR_BITS-1:0] addr,
                          output logic [31:0] data, output logic [1:0] resp);
    @(negedge clk);
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    s_axil_rready  = 1'b1;
    @(posedge clk);
    while (!s_axil_arready) @(posedge clk);
    @(negedge clk);
    s_axil_arvalid = 1'b0;
    @(posedge clk);
    while (!s_axil_rvalid) @(posedge clk);
    data = s_axil_rdata;
    resp = s_axil_rresp;
    @(negedge clk);
    s_axil_rready = 1'b0;
  endtask

  // Random beats plus the expected sums for every group
  task automatic prepare_test(input test_st t);
    pe_pkg::pixels_t   px;
    pe_pkg::weights_t  wt;
    pe_pkg::out_data_t exp_data;
    int                sums [pe_pkg::COLS][pe_pkg::ROWS];
    int                merged;
    for (int g = 0; g < t.groups; g++) begin
      sums = '{default: 0};
      for (int b = 0; b < t.cin_len; b++) begin
        for (int r = 0; r < pe_pkg::ROWS; r++) begin
          px[r] = pe_pkg::X_BITS'($random(seed));
        end
        for (int c = 0; c < pe_pkg::COLS; c++) begin
          wt[c] = pe_pkg::K_BITS'($random(seed));
        end
        for (int c = 0; c < pe_pkg::COLS; c++) begin
          for (int r = 0; r < pe_pkg::ROWS; r++) begin
            sums[c][r] += $signed(px[r]) * $signed(wt[c]);
          end
        end
        px_q.push_back(px);
        wt_q.push_back(wt);
        last_q.push_back(g == t.groups - 1 && b == t.cin_len - 1);
      end
      // Columns off the window start pick up their left neighbour
      for (int c = 0; c < pe_pkg::COLS; c++) begin
        for (int r = 0; r < pe_pkg::ROWS; r++) begin
          merged = sums[c][r];
          if (t.kw2 != 0 && c % (2 * t.kw2 + 1) != 0) begin
            merged += sums[c-1][r];
          end
          exp_data[c][r] = pe_pkg::Y_BITS'(merged);
        end
      end
      exp_q.push_back(exp_data);
      exp_last_q.push_back(g == t.groups - 1);
    end
  endtask

  task automatic send_beats();
    while (px_q.size() > 0) begin
      @(negedge clk);
      s_valid   = 1'b1;
      s_pixels  = px_q.pop_front();
      s_weights = wt_q.pop_front();
      s_last    = last_q.pop_front();
      @(posedge clk);
      while (!s_ready) @(posedge clk);
    end
    @(negedge clk);
    s_valid = 1'b0;
    s_last  = 1'b0;
  endtask

  task automatic collect_groups(input name_t name, input logic stall);
    pe_pkg::out_data_t exp_data;
    logic              exp_last;
    while (exp_q.size() > 0) begin
      @(negedge clk);
      if (stall) begin
        m_ready = ($random(seed) & 3) != 0;
      end else begin
        m_ready = 1'b1;
      end
      @(posedge clk);
      if (m_valid && m_ready) begin
        exp_data = exp_q.pop_front();
        exp_last = exp_last_q.pop_front();
        check_data(name, exp_data, m_data);
        check_flag(name, exp_last, m_last);
      end
    end
    // Stray groups are drained and show up in the count
    @(negedge clk);
    m_ready = 1'b1;
  endtask

  task automatic run_test(input test_st t);
    logic [31:0] rd;
    logic [1:0]  resp;
    write_reg(pe_pkg::ADDR_CIN_LEN, 32'(t.cin_len), resp);
    check_resp(t.name, "cin_len write response", 2'b00, resp);
    write_reg(pe_pkg::ADDR_KW2, 32'(t.kw2), resp);
    check_resp(t.name, "kw2 write response", 2'b00, resp);
    prepare_test(t);
    fork
      send_beats();
      collect_groups(t.name, t.stall);
    join
    groups_total += t.groups;
    read_reg(pe_pkg::ADDR_GRP_CNT, rd, resp);
    check_word(t.name, "group count", 32'(groups_total[15:0]), rd);
    check_resp(t.name, "group count read response", 2'b00, resp);
    read_reg(pe_pkg::ADDR_CIN_LEN, rd, resp);
    check_word(t.name, "cin_len", 32'(t.cin_len), rd);
    check_resp(t.name, "cin_len read response", 2'b00, resp);
    read_reg(pe_pkg::ADDR_KW2, rd, resp);
    check_word(t.name, "kw2", 32'(t.kw2), rd);
    check_resp(t.name, "kw2 read response", 2'b00, resp);
    read_reg(4'hc, rd, resp);
    check_word(t.name, "unmapped read", 32'h0, rd);
    check_resp(t.name, "unmapped read response", 2'b00, resp);
  endtask

  initial begin
    resetn         = 1'b0;
    s_valid        = 1'b0;
    s_last         = 1'b0;
    s_pixels       = '0;
    s_weights      = '0;
    m_ready        = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '1;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    cycle_limit    = 64 * total_beats() + 2000;
    repeat (16) @(negedge clk);
    resetn = 1'b1;
    for (int i = 0; i < $size(tests); i++) begin
      run_test(tests[i]);
    end
    print_counts();
    if (data_errs + flag_errs + word_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
design/pe_pkg.sv
design/delay_line.sv
design/beat_tagger.sv
design/engine_regs.sv
design/proc_engine.sv
design/engine_top.sv
sim/engine_tb.sv

// File: Makefile
# Verilator build and run for the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= engine_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

# Status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf $(OBJ_DIR)
